// ==== compile.f ====
common/gp_pkg.sv
hw/gp_cmd_proc/gp_cmd_proc.sv
hw/line_engine/line_engine.sv
hw/frame_filler.sv
hw/pixel_combiner.sv
hw/gp_top.sv
test/gp_sva.sv
test/tb_gp.sv

// ==== run.sh ====
#!/bin/sh
# Builds the graphics processor testbench with Verilator and runs it.
# Fails on a build error, an abnormal simulator exit or a failure in the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_gp -Mdir obj_dir -f compile.f \
	> build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_gp > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== test/tb_gp.sv ====
/*
 Directed testbench for the graphics processor. Models the command memory and
 a two-frame framebuffer, builds a reference image for each frame from the
 command lists and compares the framebuffer with it after the runs.
 */
`timescale 1ns/1ps

module tb_gp;

	localparam int NPIX = gp_pkg::SCREEN_W * gp_pkg::SCREEN_H;
	localparam logic [31:0] FRAME_BYTES = 32'(NPIX * 4);

	logic          clk = 1'b0;
	logic          rst;
	logic          start;
	logic [31:0]   list_addr;
	logic [31:0]   frame_base;
	logic          busy, done;
	logic          cmd_rd, cmd_rsp;
	logic [31:0]   cmd_rd_addr;
	logic [127:0]  cmd_rsp_data;
	logic          mem_wr;
	logic [31:0]   mem_wr_addr;
	logic [127:0]  mem_wr_data;
	logic [3:0]    mem_wr_mask;

	logic [127:0]  cmd_mem [0:255]; // 4 KB of command space
	logic [31:0]   fb [0:2047];     // frames at 0x0000 and 0x1000
	logic [31:0]   ref_mem [0:2047];
	logic [31:0]   words [$];       // list being built

	int            errors, checks, fetch_err, wr_err;
	int            fetch_total, fetch_mark;
	logic [31:0]   list_base, cur_base;
	string         cur_test;

	gp_top DUT (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] bg_word(input logic [31:0] addr);
		return (addr * 32'h9e3779b1) ^ 32'h5bd1e995;
	endfunction

	// command memory answers each read after 1 to 4 cycles
	initial begin : cmd_model
		int lat;
		logic [31:0] a, exp_a;
		void'($urandom(32'hf28b3d26));
		cmd_rsp = 1'b0;
		cmd_rsp_data = '0;
		fetch_err = 0;
		fetch_total = 0;
		forever begin
			@(posedge clk);
			if (cmd_rd === 1'b1 && !rst) begin
				a = cmd_rd_addr;
				exp_a = list_base + 32'((fetch_total - fetch_mark) * gp_pkg::BLK_BYTES);
				if (a !== exp_a) begin
					fetch_err++;
					$display("error %s fetch addr expected %h actual %h", cur_test, exp_a, a);
				end
				fetch_total++;
				lat = 1 + int'($urandom % 4);
				repeat (lat - 1) @(posedge clk);
				#1;
				cmd_rsp = 1'b1;
				cmd_rsp_data = cmd_mem[a[11:4]];
				@(posedge clk);
				#1;
				cmd_rsp = 1'b0;
			end
		end
	end

	// framebuffer applies each write under its lane mask
	initial begin : fb_model
		int i, l;
		logic [31:0] w;
		wr_err = 0;
		for (i = 0; i < 2048; i++)
			fb[i] = bg_word(32'(i * 4));
		forever begin
			@(posedge clk);
			if (mem_wr === 1'b1 && !rst) begin
				if (mem_wr_addr < cur_base || mem_wr_addr >= cur_base + FRAME_BYTES) begin
					wr_err++;
					$display("write to %h lies outside the frame at %h in test %s",
						mem_wr_addr, cur_base, cur_test);
				end
				for (l = 0; l < 4; l++) begin
					w = mem_wr_addr + 32'(l * 4);
					if (mem_wr_mask[l])
						fb[w[12:2]] = mem_wr_data[l*32 +: 32];
				end
			end
		end
	end

	function automatic logic [31:0] pt(input int x, input int y);
		return {6'd0, 10'(x), 6'd0, 10'(y)};
	endfunction

	task automatic ref_fill(input logic [23:0] c);
		int i;
		logic [31:0] a;
		for (i = 0; i < NPIX; i++) begin
			a = cur_base + 32'(i * 4);
			ref_mem[a[12:2]] = {8'h00, c};
		end
	endtask

	// reference bresenham from the start point up to the end point
	task automatic ref_line(input int x0, input int y0, input int x1, input int y1,
	                        input logic [23:0] c);
		int dx, dy, sx, sy, err, e2, x, y;
		logic [31:0] a;
		bit fin;
		dx = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy = (y1 > y0) ? y0 - y1 : y1 - y0; // kept negative
		sx = (x0 < x1) ? 1 : -1;
		sy = (y0 < y1) ? 1 : -1;
		err = dx + dy;
		x = x0;
		y = y0;
		fin = 1'b0;
		while (!fin) begin
			a = cur_base + 32'((y * gp_pkg::SCREEN_W + x) * 4);
			ref_mem[a[12:2]] = {8'h00, c};
			if (x == x1 && y == y1) begin
				fin = 1'b1;
			end else begin
				e2 = 2 * err;
				if (e2 >= dy) begin
					err += dy;
					x += sx;
				end
				if (e2 <= dx) begin
					err += dx;
					y += sy;
				end
			end
		end
	endtask

	task automatic add_fill(input logic [23:0] c);
		words.push_back({gp_pkg::OP_FILL, c});
		ref_fill(c);
	endtask

	task automatic add_line(input int x0, input int y0, input int x1, input int y1,
	                        input logic [23:0] c);
		words.push_back({gp_pkg::OP_LINE, c});
		words.push_back(pt(x0, y0));
		words.push_back(pt(x1, y1));
		ref_line(x0, y0, x1, y1, c);
	endtask

	task automatic add_stop();
		words.push_back({gp_pkg::OP_STOP, 24'h000000});
	endtask

	// pack the list into blocks with word 0 in the low bits
	task automatic load_list(input logic [31:0] laddr);
		int i, idx;
		for (i = 0; i < words.size(); i++) begin
			idx = int'(laddr[11:4]) + i / 4;
			if (i % 4 == 0)
				cmd_mem[idx] = '0;
			cmd_mem[idx][(i % 4) * 32 +: 32] = words[i];
		end
		words.delete();
	endtask

	task automatic run_list(input logic [31:0] laddr, input int poke_at, input int exp_fetches);
		int n;
		bit got;
		load_list(laddr);
		list_base = laddr;
		fetch_mark = fetch_total;
		@(posedge clk);
		#1;
		start = 1'b1;
		list_addr = laddr;
		frame_base = cur_base;
		@(posedge clk);
		#1;
		start = 1'b0;
		got = 1'b0;
		for (n = 0; n < 5000 && !got; n++) begin
			@(posedge clk);
			checks++;
			if (done) begin
				got = 1'b1;
			end else if (!busy) begin
				errors++;
				$display("busy dropped before done in test %s", cur_test);
			end
			#1;
			start = (n == poke_at); // start while busy is ignored
			if (n == poke_at) begin
				list_addr = laddr + 32'h80;
				frame_base = cur_base ^ 32'h1000;
			end
		end
		if (!got) begin
			errors++;
			$display("timeout waiting for done in test %s", cur_test);
		end else begin
			@(posedge clk);
			checks++;
			if (busy) begin
				errors++;
				$display("busy still high after done in test %s", cur_test);
			end
			if (fetch_total - fetch_mark != exp_fetches) begin
				errors++;
				$display("error %s fetch count expected %0d actual %0d",
					cur_test, exp_fetches, fetch_total - fetch_mark);
			end
		end
	endtask

	task automatic check_frame(input logic [31:0] base);
		int i;
		logic [31:0] a;
		for (i = 0; i < NPIX; i++) begin
			a = base + 32'(i * 4);
			checks++;
			if (fb[a[12:2]] !== ref_mem[a[12:2]]) begin
				errors++;
				$display("error %s pixel %h expected %h actual %h",
					cur_test, a, ref_mem[a[12:2]], fb[a[12:2]]);
			end
		end
	endtask

	task automatic test_fill();
		cur_test = "fill";
		cur_base = 32'h0000_0000;
		add_fill(24'ha1b2c3);
		add_stop();
		run_list(32'h000, -1, 1);
		check_frame(cur_base);
	endtask

	task automatic test_octants();
		int seg [11][4] = '{
			'{32, 8, 60, 12}, '{32, 8, 36, 15}, '{32, 8, 28, 15}, '{32, 8, 3, 11},
			'{32, 8, 2, 4}, '{32, 8, 29, 0}, '{32, 8, 35, 0}, '{32, 8, 63, 2},
			'{5, 14, 50, 14}, '{40, 1, 40, 14}, '{7, 2, 7, 2}
		};
		int i;
		cur_test = "octants";
		cur_base = 32'h0000_1000;
		add_fill(24'h102030);
		for (i = 0; i < 11; i++)
			add_line(seg[i][0], seg[i][1], seg[i][2], seg[i][3], 24'(32'h401000 + i * 32'h0b0d07));
		add_stop();
		run_list(32'h100, -1, 9);
		check_frame(cur_base);
	endtask

	// second line starts on a block end and the third splits its points
	task automatic test_straddle();
		cur_test = "straddle";
		cur_base = 32'h0000_0000;
		add_line(1, 1, 20, 3, 24'h00ff00);
		add_line(62, 14, 40, 10, 24'h0000ff);
		add_line(5, 15, 9, 6, 24'hff0000);
		add_stop();
		run_list(32'h400, -1, 3);
		check_frame(cur_base);
	endtask

	task automatic test_skip();
		cur_test = "skip";
		cur_base = 32'h0000_1000;
		words.push_back(32'h33000000);
		words.push_back(32'hff123456);
		add_fill(24'h00ff80);
		words.push_back(32'h05abcdef);
		add_line(0, 0, 63, 15, 24'h123456);
		add_stop();
		run_list(32'h600, -1, 2);
		check_frame(cur_base);
		cur_test = "stop_first";
		add_stop();
		run_list(32'h700, -1, 1);
		check_frame(32'h0000_0000);
		check_frame(32'h0000_1000);
	endtask

	task automatic test_busy();
		cur_test = "busy_a";
		cur_base = 32'h0000_0000;
		add_fill(24'h0a0b0c);
		add_line(3, 3, 60, 12, 24'hfedcba);
		add_stop();
		run_list(32'h800, 20, 2);
		cur_test = "busy_b";
		cur_base = 32'h0000_1000;
		add_fill(24'h332211);
		add_line(60, 0, 0, 15, 24'h778899);
		add_stop();
		run_list(32'h900, 300, 2);
		check_frame(32'h0000_0000);
		check_frame(32'h0000_1000);
	endtask

	initial begin : main
		int i;
		rst = 1'b1;
		start = 1'b0;
		list_addr = '0;
		frame_base = '0;
		errors = 0;
		checks = 0;
		fetch_mark = 0;
		list_base = '0;
		cur_base = '0;
		cur_test = "reset";
		for (i = 0; i < 2048; i++)
			ref_mem[i] = bg_word(32'(i * 4));
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		test_fill();
		test_octants();
		test_straddle();
		test_skip();
		test_busy();

		$display("checks %0d, errors %0d, fetch errors %0d, write errors %0d",
			checks, errors, fetch_err, wr_err);
		if (errors == 0 && fetch_err == 0 && wr_err == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== test/gp_sva.sv ====
/*
 Concurrent assertions on the graphics processor handshakes.
 Bound into gp_top from the testbench; failures report through $error.
 */
`timescale 1ns/1ps

module gp_sva (
	input logic                         clk,
	input logic                         rst,
	input logic                         busy,
	input logic                         cmd_rd,
	input logic                         cmd_rsp,
	input logic                         line_start,
	input logic                         fill_start,
	input logic                         mem_wr,
	input logic [gp_pkg::MASK_W-1:0]    mem_wr_mask
);

	logic rd_out; // fetch waiting for its response

	always_ff @(posedge clk) begin
		if (rst)
			rd_out <= 1'b0;
		else
			rd_out <= (rd_out && !cmd_rsp) || cmd_rd;
	end

	a_one_fetch: assert property (@(posedge clk) disable iff (rst) cmd_rd |-> !rd_out)
		else $error("cmd_rd issued while a fetch is outstanding");

	a_one_engine: assert property (@(posedge clk) disable iff (rst) !(line_start && fill_start))
		else $error("line_start and fill_start high together");

	a_wr_mask: assert property (@(posedge clk) disable iff (rst) mem_wr |-> mem_wr_mask != '0)
		else $error("mem_wr with an empty lane mask");

	// busy must come out of reset low
	a_reset_busy: assert property (@(posedge clk) rst |=> !busy)
		else $error("busy high in the cycle after reset");

endmodule

bind gp_top gp_sva u_sva (
	.clk(clk), .rst(rst), .busy(busy), .cmd_rd(cmd_rd), .cmd_rsp(cmd_rsp),
	.line_start(line_start), .fill_start(fill_start),
	.mem_wr(mem_wr), .mem_wr_mask(mem_wr_mask)
);

// ==== hw/gp_top.sv ====
/*
 Graphics processor top level. Connects the command processor to the line
 engine and frame filler, and both engines to the write combiner.
 */
`timescale 1ns/1ps

module gp_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         start,
	input  logic [gp_pkg::ADDR_W-1:0]    list_addr,
	input  logic [gp_pkg::ADDR_W-1:0]    frame_base,
	output logic                         busy,
	output logic                         done,
	output logic                         cmd_rd,
	output logic [gp_pkg::ADDR_W-1:0]    cmd_rd_addr,
	input  logic                         cmd_rsp,
	input  logic [gp_pkg::BLK_W-1:0]     cmd_rsp_data,
	output logic                         mem_wr,
	output logic [gp_pkg::ADDR_W-1:0]    mem_wr_addr,
	output logic [gp_pkg::BLK_W-1:0]     mem_wr_data,
	output logic [gp_pkg::MASK_W-1:0]    mem_wr_mask
);

	logic                        line_start, fill_start;
	logic [gp_pkg::COORD_W-1:0]  x0, y0, x1, y1;
	logic [gp_pkg::COLOR_W-1:0]  color;
	logic [gp_pkg::ADDR_W-1:0]   base_addr; // frame base latched at start

	logic                        le_valid, le_done;
	logic [gp_pkg::COORD_W-1:0]  le_x, le_y;
	logic [gp_pkg::COLOR_W-1:0]  le_color;
	logic                        ff_valid, ff_done;
	logic [gp_pkg::COORD_W-1:0]  ff_x, ff_y;
	logic [gp_pkg::COLOR_W-1:0]  ff_color;

	gp_cmd_proc u_cmd (
		.clk(clk), .rst(rst), .start(start), .list_addr(list_addr),
		.frame_base(frame_base), .busy(busy), .done(done),
		.cmd_rd(cmd_rd), .cmd_rd_addr(cmd_rd_addr),
		.cmd_rsp(cmd_rsp), .cmd_rsp_data(cmd_rsp_data),
		.line_start(line_start), .fill_start(fill_start),
		.x0(x0), .y0(y0), .x1(x1), .y1(y1), .color(color),
		.line_done(le_done), .fill_done(ff_done), .base_addr(base_addr)
	);

	line_engine u_line (
		.clk(clk), .rst(rst), .line_start(line_start),
		.x0(x0), .y0(y0), .x1(x1), .y1(y1), .color(color),
		.pix_valid(le_valid), .pix_x(le_x), .pix_y(le_y),
		.pix_color(le_color), .line_done(le_done)
	);

	frame_filler u_fill (
		.clk(clk), .rst(rst), .fill_start(fill_start), .color(color),
		.pix_valid(ff_valid), .pix_x(ff_x), .pix_y(ff_y),
		.pix_color(ff_color), .fill_done(ff_done)
	);

	pixel_combiner u_comb (
		.clk(clk), .rst(rst), .frame_base(base_addr),
		.le_valid(le_valid), .le_x(le_x), .le_y(le_y),
		.le_color(le_color), .le_done(le_done),
		.ff_valid(ff_valid), .ff_x(ff_x), .ff_y(ff_y),
		.ff_color(ff_color), .ff_done(ff_done),
		.mem_wr(mem_wr), .mem_wr_addr(mem_wr_addr),
		.mem_wr_data(mem_wr_data), .mem_wr_mask(mem_wr_mask)
	);

endmodule

// ==== hw/pixel_combiner.sv ====
/*
 Pixel write combiner. Takes pixels from either engine, keeps one open
 framebuffer block with a lane mask and writes it out when a pixel falls in
 another block or when an engine signals done.
 */
`timescale 1ns/1ps

module pixel_combiner (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [gp_pkg::ADDR_W-1:0]    frame_base,
	input  logic                         le_valid,
	input  logic [gp_pkg::COORD_W-1:0]   le_x,
	input  logic [gp_pkg::COORD_W-1:0]   le_y,
	input  logic [gp_pkg::COLOR_W-1:0]   le_color,
	input  logic                         le_done,
	input  logic                         ff_valid,
	input  logic [gp_pkg::COORD_W-1:0]   ff_x,
	input  logic [gp_pkg::COORD_W-1:0]   ff_y,
	input  logic [gp_pkg::COLOR_W-1:0]   ff_color,
	input  logic                         ff_done,
	output logic                         mem_wr,
	output logic [gp_pkg::ADDR_W-1:0]    mem_wr_addr,
	output logic [gp_pkg::BLK_W-1:0]     mem_wr_data,
	output logic [gp_pkg::MASK_W-1:0]    mem_wr_mask
);

	logic                                   p_valid, p_done;
	logic [gp_pkg::COORD_W-1:0]             p_x, p_y;
	logic [gp_pkg::COLOR_W-1:0]             p_color;
	logic [gp_pkg::ADDR_W-1:0]              pix_off, pix_addr, blk_addr;
	logic [$clog2(gp_pkg::PIX_PER_BLK)-1:0] lane;
	logic                                   same_blk, wr_old;
	logic                                   open_vld, flush_pend;
	logic [gp_pkg::ADDR_W-1:0]              open_addr;
	logic [gp_pkg::BLK_W-1:0]               open_data, mrg_data;
	logic [gp_pkg::MASK_W-1:0]              open_mask, mrg_mask;

	// engines never run together, take whichever is active
	assign p_valid = le_valid | ff_valid;
	assign p_done = le_done | ff_done;
	assign p_x = le_valid ? le_x : ff_x;
	assign p_y = le_valid ? le_y : ff_y;
	assign p_color = le_valid ? le_color : ff_color;

	assign pix_off = p_y * gp_pkg::SCREEN_W + p_x;
	assign pix_addr = frame_base + (pix_off << 2);
	assign blk_addr = {pix_addr[gp_pkg::ADDR_W-1:4], 4'b0000};
	assign lane = pix_addr[3:2];

	assign same_blk = open_vld && (blk_addr == open_addr);
	assign wr_old = open_vld && !same_blk; // open block must go out first

	always_comb begin
		mrg_data = same_blk ? open_data : '0;
		mrg_mask = same_blk ? open_mask : '0;
		mrg_data[lane*gp_pkg::WORD_W +: gp_pkg::WORD_W] =
			{{(gp_pkg::WORD_W-gp_pkg::COLOR_W){1'b0}}, p_color};
		mrg_mask[lane] = 1'b1; // later pixel wins the lane
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wr <= 1'b0;
			open_vld <= 1'b0;
			flush_pend <= 1'b0;
		end else begin
			mem_wr <= 1'b0;
			flush_pend <= 1'b0;
			if (flush_pend) begin
				mem_wr <= 1'b1;
				open_vld <= 1'b0;
			end else if (p_valid) begin
				mem_wr <= wr_old || p_done;
				flush_pend <= p_done && wr_old; // last pixel opened a new block
				open_vld <= !p_done || wr_old;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (flush_pend) begin
			mem_wr_addr <= open_addr;
			mem_wr_data <= open_data;
			mem_wr_mask <= open_mask;
		end else if (p_valid) begin
			if (wr_old) begin
				mem_wr_addr <= open_addr;
				mem_wr_data <= open_data;
				mem_wr_mask <= open_mask;
			end else begin
				mem_wr_addr <= blk_addr;
				mem_wr_data <= mrg_data;
				mem_wr_mask <= mrg_mask;
			end
			open_addr <= blk_addr;
			open_data <= mrg_data;
			open_mask <= mrg_mask;
		end
	end

endmodule

// ==== hw/frame_filler.sv ====
/*
 Frame filler. On fill_start it sweeps the whole screen row by row in one
 color, one pixel per cycle, and raises fill_done on the last pixel.
 */
`timescale 1ns/1ps

module frame_filler (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         fill_start,
	input  logic [gp_pkg::COLOR_W-1:0]   color,
	output logic                         pix_valid,
	output logic [gp_pkg::COORD_W-1:0]   pix_x,
	output logic [gp_pkg::COORD_W-1:0]   pix_y,
	output logic [gp_pkg::COLOR_W-1:0]   pix_color,
	output logic                         fill_done
);

	logic active;
	logic row_end;

	assign row_end = (pix_x == gp_pkg::SCREEN_W - 1);
	assign pix_valid = active;
	assign fill_done = active && row_end && (pix_y == gp_pkg::SCREEN_H - 1);

	always_ff @(posedge clk) begin
		if (rst)
			active <= 1'b0;
		else if (fill_start)
			active <= 1'b1;
		else if (fill_done)
			active <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fill_start) begin
			pix_x <= '0;
			pix_y <= '0;
			pix_color <= color;
		end else if (active) begin
			if (row_end) begin // wrap to next row
				pix_x <= '0;
				pix_y <= pix_y + 1'b1;
			end else begin
				pix_x <= pix_x + 1'b1;
			end
		end
	end

endmodule

// ==== hw/line_engine/line_engine.sv ====
/*
 Bresenham line engine. Latches both end points on line_start and emits one
 pixel per cycle from the start point to the end point, in any octant.
 line_done comes with the last pixel.
 */
`timescale 1ns/1ps

module line_engine (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         line_start,
	input  logic [gp_pkg::COORD_W-1:0]   x0,
	input  logic [gp_pkg::COORD_W-1:0]   y0,
	input  logic [gp_pkg::COORD_W-1:0]   x1,
	input  logic [gp_pkg::COORD_W-1:0]   y1,
	input  logic [gp_pkg::COLOR_W-1:0]   color,
	output logic                         pix_valid,
	output logic [gp_pkg::COORD_W-1:0]   pix_x,
	output logic [gp_pkg::COORD_W-1:0]   pix_y,
	output logic [gp_pkg::COLOR_W-1:0]   pix_color,
	output logic                         line_done
);

	logic                               active;
	logic [gp_pkg::COORD_W-1:0]         cx, cy; // current point
	logic [gp_pkg::COORD_W-1:0]         ex, ey; // end point
	logic                               sx_neg, sy_neg;
	logic signed [gp_pkg::ERR_W-1:0]    dx, dy; // dy held negative
	logic signed [gp_pkg::ERR_W-1:0]    err, e2, err_nx;
	logic signed [gp_pkg::ERR_W-1:0]    adx, ady;
	logic                               step_x, step_y;

	// absolute extents, zero extended
	assign adx = (x1 >= x0) ? {{(gp_pkg::ERR_W-gp_pkg::COORD_W){1'b0}}, x1 - x0}
	                        : {{(gp_pkg::ERR_W-gp_pkg::COORD_W){1'b0}}, x0 - x1};
	assign ady = (y1 >= y0) ? {{(gp_pkg::ERR_W-gp_pkg::COORD_W){1'b0}}, y1 - y0}
	                        : {{(gp_pkg::ERR_W-gp_pkg::COORD_W){1'b0}}, y0 - y1};

	assign e2 = err <<< 1;
	assign step_x = (e2 >= dy);
	assign step_y = (e2 <= dx);

	always_comb begin
		err_nx = err;
		if (step_x)
			err_nx = err_nx + dy;
		if (step_y)
			err_nx = err_nx + dx;
	end

	assign pix_valid = active;
	assign pix_x = cx;
	assign pix_y = cy;
	assign line_done = active && (cx == ex) && (cy == ey);

	always_ff @(posedge clk) begin
		if (rst)
			active <= 1'b0;
		else if (line_start)
			active <= 1'b1;
		else if (line_done)
			active <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			cx <= x0;
			cy <= y0;
			ex <= x1;
			ey <= y1;
			dx <= adx;
			dy <= -ady;
			err <= adx - ady;
			sx_neg <= (x1 < x0);
			sy_neg <= (y1 < y0);
			pix_color <= color;
		end else if (active) begin
			if (step_x)
				cx <= sx_neg ? cx - 1'b1 : cx + 1'b1;
			if (step_y)
				cy <= sy_neg ? cy - 1'b1 : cy + 1'b1;
			err <= err_nx;
		end
	end

endmodule

// ==== hw/gp_cmd_proc/gp_cmd_proc.sv ====
/*
 Command processor. Fetches 128-bit blocks of command words from the list
 address, decodes them in order and hands line and fill jobs to the engines,
 waiting for each engine's done before moving on. Also holds the frame base.
 */
`timescale 1ns/1ps

module gp_cmd_proc (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         start,
	input  logic [gp_pkg::ADDR_W-1:0]    list_addr,
	input  logic [gp_pkg::ADDR_W-1:0]    frame_base,
	output logic                         busy,
	output logic                         done,
	output logic                         cmd_rd,
	output logic [gp_pkg::ADDR_W-1:0]    cmd_rd_addr,
	input  logic                         cmd_rsp,
	input  logic [gp_pkg::BLK_W-1:0]     cmd_rsp_data,
	output logic                         line_start,
	output logic                         fill_start,
	output logic [gp_pkg::COORD_W-1:0]   x0,
	output logic [gp_pkg::COORD_W-1:0]   y0,
	output logic [gp_pkg::COORD_W-1:0]   x1,
	output logic [gp_pkg::COORD_W-1:0]   y1,
	output logic [gp_pkg::COLOR_W-1:0]   color,
	input  logic                         line_done,
	input  logic                         fill_done,
	output logic [gp_pkg::ADDR_W-1:0]    base_addr
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_WAIT,
		S_DECODE,
		S_GATHER,
		S_RUN
	} state_t;

	state_t state, ret_state; // ret_state is where a fetch returns to

	logic [gp_pkg::BLK_W-1:0]   block;
	logic [gp_pkg::IDX_W-1:0]   idx;
	logic [gp_pkg::ADDR_W-1:0]  fetch_addr;
	logic [gp_pkg::WORD_W-1:0]  word;
	logic [7:0]                 op;
	logic                       pt_sel; // 0 start point, 1 end point
	logic                       stop_seen;
	logic                       blk_last;
	logic                       start_ok;

	assign word = block[idx[gp_pkg::IDX_W-2:0]*gp_pkg::WORD_W +: gp_pkg::WORD_W];
	assign op = word[gp_pkg::WORD_W-1 -: 8];
	assign blk_last = (idx == gp_pkg::WORDS_PER_BLK - 1);
	assign start_ok = (state == S_IDLE) && start && !busy;

	assign cmd_rd = (state == S_FETCH);
	assign cmd_rd_addr = fetch_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			ret_state <= S_DECODE;
			idx <= '0;
			pt_sel <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			stop_seen <= 1'b0;
			line_start <= 1'b0;
			fill_start <= 1'b0;
		end else begin
			line_start <= 1'b0;
			fill_start <= 1'b0;
			stop_seen <= 1'b0;
			done <= stop_seen; // one spare cycle so the combiner drains
			if (done)
				busy <= 1'b0;

			case (state)
				S_IDLE: begin
					if (start_ok) begin
						busy <= 1'b1;
						ret_state <= S_DECODE;
						state <= S_FETCH;
					end
				end
				S_FETCH: state <= S_WAIT; // single read strobe
				S_WAIT: begin
					if (cmd_rsp) begin
						idx <= '0;
						state <= ret_state;
					end
				end
				S_DECODE: begin
					if (op == gp_pkg::OP_STOP) begin
						stop_seen <= 1'b1;
						state <= S_IDLE;
					end else begin
						idx <= idx + 1'b1;
						if (op == gp_pkg::OP_FILL) begin
							fill_start <= 1'b1;
							state <= S_RUN;
						end else if (op == gp_pkg::OP_LINE) begin
							pt_sel <= 1'b0;
							ret_state <= S_GATHER;
							state <= blk_last ? S_FETCH : S_GATHER;
						end else begin
							// unknown opcode, skip the word
							ret_state <= S_DECODE;
							state <= blk_last ? S_FETCH : S_DECODE;
						end
					end
				end
				S_GATHER: begin
					idx <= idx + 1'b1;
					pt_sel <= 1'b1;
					if (pt_sel) begin
						line_start <= 1'b1; // end point latched this cycle
						state <= S_RUN;
					end else begin
						state <= blk_last ? S_FETCH : S_GATHER;
					end
				end
				S_RUN: begin
					if (line_done || fill_done) begin
						ret_state <= S_DECODE;
						state <= (idx == gp_pkg::WORDS_PER_BLK) ? S_FETCH : S_DECODE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// addresses, block buffer and engine arguments
	always_ff @(posedge clk) begin
		if (start_ok) begin
			fetch_addr <= list_addr;
			base_addr <= frame_base;
		end else if (state == S_FETCH) begin
			fetch_addr <= fetch_addr + gp_pkg::BLK_BYTES; // point at next block
		end
		if (state == S_WAIT && cmd_rsp)
			block <= cmd_rsp_data;
		if (state == S_DECODE && (op == gp_pkg::OP_FILL || op == gp_pkg::OP_LINE))
			color <= word[gp_pkg::COLOR_W-1:0];
		if (state == S_GATHER) begin
			if (pt_sel) begin
				x1 <= word[25:16];
				y1 <= word[9:0];
			end else begin
				x0 <= word[25:16];
				y0 <= word[9:0];
			end
		end
	end

endmodule

// ==== common/gp_pkg.sv ====
/*
 Shared constants for the graphics processor: command opcodes, screen geometry
 and bus widths. Every design file refers to them as gp_pkg::name.
 */
package gp_pkg;

	// command opcodes, top byte of a command word
	localparam logic [7:0] OP_STOP = 8'd0;
	localparam logic [7:0] OP_FILL = 8'd1;
	localparam logic [7:0] OP_LINE = 8'd2;

	// screen geometry, kept small so a fill is short
	localparam int SCREEN_W = 64;
	localparam int SCREEN_H = 16;

	localparam int COORD_W = 10;
	localparam int COLOR_W = 24;

	localparam int ADDR_W = 32; // byte addresses
	localparam int WORD_W = 32; // command word and stored pixel
	localparam int BLK_W = 128; // memory word

	localparam int PIX_PER_BLK = 4;
	localparam int MASK_W = 4; // one enable per pixel lane
	localparam int BLK_BYTES = 16; // stride between command blocks

	localparam int WORDS_PER_BLK = BLK_W / WORD_W;
	// word index counts one past the last word to mark an empty block
	localparam int IDX_W = $clog2(WORDS_PER_BLK) + 1;

	// bresenham error term, holds twice the largest extent plus sign
	localparam int ERR_W = COORD_W + 3;

endpackage
